/* fetch_stream_if.sv */
// fetched word stream between prefetch buffer and IF-ID register
// a word moves on a clock edge with valid and ready both high
// valid and payload hold until transfer or until a branch flushes the buffer
`timescale 1ns/1ns
`default_nettype none

interface fetch_stream_if import if_pkg::*; ();

  // head of the prefetch FIFO is valid
  logic   valid;
  // ID side can take the word this cycle
  logic   ready;
  // instruction word
  instr_t rdata;
  // address the word was fetched from
  addr_t  addr;
  // bus error seen on this word
  logic   err;

  // prefetch buffer side
  modport producer (
    output valid,
    output rdata,
    output addr,
    output err,
    input  ready
  );

  // IF-ID register side
  modport consumer (
    input  valid,
    input  rdata,
    input  addr,
    input  err,
    output ready
  );

endinterface

`default_nettype wire

/* if_id_regs.sv */
// IF-ID pipeline register, loads only when the ID stage is ready
// valid holds until the ID stage clears it, new marks the first cycle of a word
`timescale 1ns/1ns
`default_nettype none

module if_id_regs import if_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  fetch_stream_if.consumer in,
  input  logic   id_in_ready_i,
  input  logic   pc_set_i,
  input  logic   instr_valid_clear_i,
  output logic   instr_valid_id_o,
  output logic   instr_new_id_o,
  output instr_t instr_rdata_id_o,
  output logic   instr_fetch_err_o,
  output addr_t  pc_id_o
);

  logic xfer;
  logic valid_d;

  // stall from ID backs up into the prefetch FIFO
  assign in.ready = id_in_ready_i;
  assign xfer     = in.valid & in.ready;

  // a word entering with a pc_set is squashed, old valid drops on clear
  assign valid_d = (xfer & ~pc_set_i) | (instr_valid_id_o & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= valid_d;
      // high for one cycle after each accepted word
      instr_new_id_o   <= xfer;
    end
  end

  //////////////////////////////
  // payload
  //////////////////////////////

  // frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      instr_rdata_id_o  <= in.rdata;
      instr_fetch_err_o <= in.err;
      pc_id_o           <= in.addr;
    end
  end

  // stream rule seen from this side, a waiting word only leaves on a flush
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    in.valid && !in.ready && !pc_set_i |=>
      in.valid && $stable(in.addr) && $stable(in.rdata) && $stable(in.err))
    else $error("fetch stream word changed before transfer");

endmodule

`default_nettype wire

/* if_pkg.sv */
// shared types and constants for the instruction fetch stage
// every instruction is 32 bits and word aligned, no compressed support
`default_nettype none

package if_pkg;

  //////////////////////////////
  // data widths
  //////////////////////////////

  // byte address on the instruction bus
  typedef logic [31:0] addr_t;
  // one fetched instruction word
  typedef logic [31:0] instr_t;
  // interrupt vector index into the mtvec table
  typedef logic [4:0]  irq_vec_t;

  //////////////////////////////
  // selectors
  //////////////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // source of the handler address when pc_mux selects PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  //////////////////////////////
  // fixed vectors
  //////////////////////////////

  // boot entry sits this far above the aligned boot base
  localparam logic [7:0] BOOT_OFFSET = 8'h80;
  // all internal interrupts share the nmi slot
  localparam irq_vec_t IRQ_NM_VEC = 5'd31;
  // low bits cleared in boot address and mtvec
  localparam int unsigned VEC_ALIGN_BITS = 8;

endpackage

`default_nettype wire

/* if_stage.sv */
// instruction fetch stage top, RV32 without compressed instructions
// boot_addr_i and csr_mtvec_i must be 256 byte aligned
// fetch begins only after req_i and a first pc_set_i, normally PC_BOOT
`timescale 1ns/1ns
`default_nettype none

module if_stage import if_pkg::*; #(
  parameter int unsigned FifoDepth       = 3,
  parameter addr_t       DmHaltAddr      = 32'h1A11_0800,
  parameter addr_t       DmExceptionAddr = 32'h1A11_0808
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  addr_t       boot_addr_i,
  input  logic        req_i,

  // instruction bus
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  instr_t      instr_rdata_i,
  input  logic        instr_bus_err_i,

  // to the ID stage
  output logic        instr_valid_id_o,
  output logic        instr_new_id_o,
  output instr_t      instr_rdata_id_o,
  output logic        instr_fetch_err_o,
  output addr_t       pc_if_o,
  output addr_t       pc_id_o,

  // control from the ID stage and controller
  input  logic        instr_valid_clear_i,
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  irq_vec_t    irq_vec_i,
  input  logic        irq_int_i,
  input  addr_t       branch_target_i,

  // CSRs
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  output logic        csr_mtvec_init_o,

  input  logic        id_in_ready_i,
  output logic        if_busy_o
);

  addr_t branch_addr;

  fetch_stream_if fetch_if ();

  //////////////////////////////
  // next pc
  //////////////////////////////

  pc_select #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) i_pc_select (
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_vec_i        (irq_vec_i),
    .irq_int_i        (irq_int_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  //////////////////////////////
  // fetch and buffer
  //////////////////////////////

  // every pc_set is a branch for the prefetcher
  prefetch_buffer #(
    .FifoDepth (FifoDepth)
  ) i_prefetch_buffer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .branch_i        (pc_set_i),
    .branch_addr_i   (branch_addr),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_bus_err_i (instr_bus_err_i),
    .busy_o          (if_busy_o),
    .out             (fetch_if.producer)
  );

  // address of the word waiting at the FIFO head
  assign pc_if_o = fetch_if.addr;

  //////////////////////////////
  // IF-ID register
  //////////////////////////////

  if_id_regs i_if_id_regs (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .in                  (fetch_if.consumer),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o)
  );

endmodule

`default_nettype wire

/* list.f */
if_pkg.sv
fetch_stream_if.sv
pc_select.sv
prefetch_buffer.sv
if_id_regs.sv
if_stage.sv
tb_instr_mem.sv
tb_if_stage.sv

/* pc_select.sv */
// next fetch address selection, purely combinational
// boot address and mtvec are taken as 256 byte aligned, low bits ignored
// debug addresses come in as parameters from the top level
`timescale 1ns/1ns
`default_nettype none

module pc_select import if_pkg::*; #(
  parameter addr_t DmHaltAddr      = 32'h1A11_0800,
  parameter addr_t DmExceptionAddr = 32'h1A11_0808
) (
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  irq_vec_t    irq_vec_i,
  input  logic        irq_int_i,
  input  addr_t       boot_addr_i,
  input  addr_t       branch_target_i,
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  output addr_t       branch_addr_o,
  output logic        csr_mtvec_init_o
);

  addr_t    mtvec_base;
  addr_t    boot_base;
  irq_vec_t irq_vec;
  addr_t    exc_pc;

  // table bases with the alignment bits cleared
  assign mtvec_base = {csr_mtvec_i[31:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}};
  assign boot_base  = {boot_addr_i[31:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}};

  // internal interrupts are all routed to the nmi entry
  assign irq_vec = irq_int_i ? IRQ_NM_VEC : irq_vec_i;

  //////////////////////////////
  // handler address
  //////////////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = mtvec_base;
      // vectored mode, one word per vector
      EXC_PC_IRQ:     exc_pc = mtvec_base + addr_t'({irq_vec, 2'b00});
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:        exc_pc = mtvec_base;
    endcase
  end

  //////////////////////////////
  // next fetch address
  //////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: branch_addr_o = boot_base + addr_t'(BOOT_OFFSET);
      PC_JUMP: branch_addr_o = branch_target_i;
      PC_EXC:  branch_addr_o = exc_pc;
      // return from trap handler
      PC_ERET: branch_addr_o = csr_mepc_i;
      // return from debug mode
      PC_DRET: branch_addr_o = csr_depc_i;
      default: branch_addr_o = boot_base + addr_t'(BOOT_OFFSET);
    endcase
  end

  // CSR file loads its mtvec reset value in the boot cycle
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

  // handler select must be driven whenever a new pc is taken
  always_comb begin
    if (pc_set_i) begin
      assert (!$isunknown(exc_pc_mux_i))
        else $error("exc_pc_mux_i has unknown bits while pc_set_i is high");
    end
  end

endmodule

`default_nettype wire

/* prefetch_buffer.sv */
// instruction bus master with a small response FIFO
// at most two requests in flight, a request waits for FIFO room for all of them
// a branch empties the FIFO at once and drops responses still in flight
// a request that is waiting for grant stays on the bus, its response is dropped
`timescale 1ns/1ns
`default_nettype none

module prefetch_buffer import if_pkg::*; #(
  parameter int unsigned FifoDepth = 3
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   req_i,
  input  logic   branch_i,
  input  addr_t  branch_addr_i,
  output logic   instr_req_o,
  output addr_t  instr_addr_o,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  input  instr_t instr_rdata_i,
  input  logic   instr_bus_err_i,
  output logic   busy_o,
  fetch_stream_if.producer out
);

  localparam int unsigned PtrW = $clog2(FifoDepth);
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  addr_t           branch_addr_w;
  logic            started_q;
  addr_t           fetch_addr_q;
  logic            held_q;
  addr_t           held_addr_q;
  logic            held_disc_q;
  logic            new_req;
  logic            gnt_xfer;
  logic            gnt_disc;
  logic [1:0]      out_cnt_q;
  logic [1:0]      out_cnt_d;
  logic [1:0]      disc_q;
  logic [1:0]      disc_d;
  logic [1:0]      slot_live;
  logic            held_live;
  logic [2:0]      live_cnt;
  logic            space_ok;
  logic            push;
  logic            pop;
  addr_t           resp_addr_q;
  instr_t          fifo_rdata_q [FifoDepth];
  addr_t           fifo_addr_q  [FifoDepth];
  logic            fifo_err_q   [FifoDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] fifo_cnt_q;

  // fetches are always whole words
  assign branch_addr_w = {branch_addr_i[31:2], 2'b00};

  //////////////////////////////
  // request issue
  //////////////////////////////

  // outstanding responses that will land in the FIFO
  assign slot_live[0] = (out_cnt_q != 2'd0) & ~disc_q[0];
  assign slot_live[1] = out_cnt_q[1] & ~disc_q[1];
  assign held_live    = held_q & ~held_disc_q;
  assign live_cnt     = 3'(slot_live[0]) + 3'(slot_live[1]) + 3'(held_live);

  // room for every live request plus one more
  assign space_ok = (32'(fifo_cnt_q) + 32'(live_cnt)) < FifoDepth;

  // a branch frees the whole FIFO, so only the in-flight limit applies
  assign new_req = ~held_q & req_i & (out_cnt_q != 2'd2) &
                   (branch_i | (started_q & space_ok));

  assign instr_req_o  = held_q | new_req;
  assign instr_addr_o = held_q   ? held_addr_q   :
                        branch_i ? branch_addr_w : fetch_addr_q;
  assign gnt_xfer     = instr_req_o & instr_gnt_i;

  // a held request that was overtaken by a branch returns stale data
  assign gnt_disc = held_q & (held_disc_q | branch_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q   <= 1'b0;
      held_q      <= 1'b0;
      held_disc_q <= 1'b0;
    end else begin
      // no fetching before the first pc is set
      if (branch_i) begin
        started_q <= 1'b1;
      end
      held_q <= instr_req_o & ~instr_gnt_i;
      if (new_req) begin
        held_disc_q <= 1'b0;
      end else if (held_q) begin
        held_disc_q <= held_disc_q | branch_i;
      end
    end
  end

  // next sequential address and the address of a waiting request
  always_ff @(posedge clk_i) begin
    if (new_req) begin
      fetch_addr_q <= instr_addr_o + 32'd4;
      held_addr_q  <= instr_addr_o;
    end else if (branch_i) begin
      fetch_addr_q <= branch_addr_w;
    end
  end

  //////////////////////////////
  // outstanding tracking
  //////////////////////////////

  // slot 0 is the oldest granted request
  always_comb begin
    out_cnt_d = out_cnt_q;
    disc_d    = disc_q | {2{branch_i}};
    if (instr_rvalid_i) begin
      out_cnt_d = out_cnt_d - 2'd1;
      disc_d    = {1'b0, disc_d[1]};
    end
    if (gnt_xfer) begin
      disc_d[out_cnt_d[0]] = gnt_disc;
      out_cnt_d            = out_cnt_d + 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_cnt_q <= 2'd0;
      disc_q    <= 2'b00;
    end else begin
      out_cnt_q <= out_cnt_d;
      disc_q    <= disc_d;
    end
  end

  assign busy_o = held_q | (out_cnt_q != 2'd0);

  //////////////////////////////
  // response FIFO
  //////////////////////////////

  // responses in the branch cycle belong to the old stream
  assign push = instr_rvalid_i & ~disc_q[0] & ~branch_i;
  assign pop  = out.valid & out.ready;

  // live responses come back in order from the branch target upward
  always_ff @(posedge clk_i) begin
    if (branch_i) begin
      resp_addr_q <= branch_addr_w;
    end else if (push) begin
      resp_addr_q <= resp_addr_q + 32'd4;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else if (branch_i) begin
      // flush
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fifo_cnt_q <= fifo_cnt_q + CntW'(push) - CntW'(pop);
    end
  end

  // word, address and error travel together
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_rdata_q[wr_ptr_q] <= instr_rdata_i;
      fifo_addr_q[wr_ptr_q]  <= resp_addr_q;
      fifo_err_q[wr_ptr_q]   <= instr_bus_err_i;
    end
  end

  assign out.valid = (fifo_cnt_q != '0);
  assign out.rdata = fifo_rdata_q[rd_ptr_q];
  assign out.addr  = fifo_addr_q[rd_ptr_q];
  assign out.err   = fifo_err_q[rd_ptr_q];

  //////////////////////////////
  // checks
  //////////////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> instr_addr_o[1:0] == 2'b00)
    else $error("instruction request address not word aligned");

  // bus rule, request and address held until granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instruction request dropped or changed before grant");

  // the issue reservation must keep a slot for every returning word
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    push && !pop |-> 32'(fifo_cnt_q) < FifoDepth)
    else $error("prefetch FIFO overflow");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_if_stage -f list.f -o sim_if_stage \
  > build.log 2>&1 \
  && ./obj_dir/sim_if_stage > sim.log 2>&1 \
  && grep -q "^Regression passed$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* tb_if_stage.sv */
// testbench for the fetch stage, acts as controller, ID stage and checker
// the ID side clears valid whenever it is ready, so new with valid marks a live word
`timescale 1ns/1ns
`default_nettype none

module tb_if_stage import if_pkg::*; ();

  localparam addr_t HaltAddr = 32'h1A11_0800;
  localparam addr_t DbgExcAddr = 32'h1A11_0808;
  localparam addr_t BootAddr = 32'h0000_8000;
  localparam addr_t Mepc = 32'h0000_3404;
  localparam addr_t Depc = 32'h0000_5508;
  localparam addr_t Mtvec = 32'h0000_1000;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic req_i = 1'b0;
  logic instr_req_o;
  logic instr_gnt_i;
  logic instr_rvalid_i;
  logic instr_bus_err_i;
  addr_t instr_addr_o;
  instr_t instr_rdata_i;
  logic instr_valid_id_o;
  logic instr_new_id_o;
  logic instr_fetch_err_o;
  logic csr_mtvec_init_o;
  logic if_busy_o;
  instr_t instr_rdata_id_o;
  addr_t pc_if_o;
  addr_t pc_id_o;
  logic instr_valid_clear_i = 1'b0;
  logic pc_set_i = 1'b0;
  pc_sel_e pc_mux_i = PC_BOOT;
  exc_pc_sel_e exc_pc_mux_i = EXC_PC_EXC;
  irq_vec_t irq_vec_i = '0;
  logic irq_int_i = 1'b0;
  addr_t branch_target_i = '0;
  logic id_in_ready_i = 1'b0;

  logic [31:0] rng = 32'h3893b28f;
  int ready_mode = 0;
  int errors = 0;
  int checks = 0;
  int n_words = 0;
  int in_flight = 0;
  logic prev_clear = 1'b0;
  logic boot_set = 1'b0;
  addr_t exp_q = '0;
  addr_t head_pc = '0;

  if_stage #(.FifoDepth(3), .DmHaltAddr(HaltAddr), .DmExceptionAddr(DbgExcAddr)) i_if_stage (
    .clk_i, .rst_ni, .boot_addr_i(BootAddr), .req_i,
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rvalid_i, .instr_rdata_i,
    .instr_bus_err_i, .instr_valid_id_o, .instr_new_id_o, .instr_rdata_id_o,
    .instr_fetch_err_o, .pc_if_o, .pc_id_o, .instr_valid_clear_i, .pc_set_i, .pc_mux_i,
    .exc_pc_mux_i, .irq_vec_i, .irq_int_i, .branch_target_i, .csr_mepc_i(Mepc),
    .csr_depc_i(Depc), .csr_mtvec_i(Mtvec), .csr_mtvec_init_o, .id_in_ready_i, .if_busy_o
  );

  tb_instr_mem #(.Seed(32'h3893b28f)) i_mem (
    .clk_i, .rst_ni, .req_i(instr_req_o), .addr_i(instr_addr_o), .gnt_o(instr_gnt_i),
    .rvalid_o(instr_rvalid_i), .rdata_o(instr_rdata_i), .err_o(instr_bus_err_i)
  );

  initial begin
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic addr_t exp_fetch_addr(input pc_sel_e mux, input exc_pc_sel_e emux,
                                           input irq_vec_t vec, input logic intr,
                                           input addr_t target);
    addr_t tvec;
    tvec = Mtvec & 32'hFFFF_FF00;
    case (mux)
      PC_BOOT: return (BootAddr & 32'hFFFF_FF00) + 32'h80;
      PC_JUMP: return target;
      PC_ERET: return Mepc;
      PC_DRET: return Depc;
      default: begin
        case (emux)
          EXC_PC_IRQ: return tvec + 4 * (intr ? 32'd31 : 32'(vec));
          EXC_PC_DBD: return HaltAddr;
          EXC_PC_DBG_EXC: return DbgExcAddr;
          default: return tvec;
        endcase
      end
    endcase
  endfunction

  function automatic instr_t exp_instr(input addr_t a);
    return ~{a[31:2], 2'b00};
  endfunction

  function automatic logic exp_err(input addr_t a);
    return a[11:8] == 4'hE;
  endfunction

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_instr(input string what, input instr_t got, input instr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////
  // ID stage and checker
  //////////////////////////////

  // ready 0 always, 1 random, 2 stalled
  always @(posedge clk_i) begin
    rng = xorshift32(rng);
    id_in_ready_i <= (ready_mode == 0) | ((ready_mode == 1) & rng[3]);
    instr_valid_clear_i <= (ready_mode == 0) | ((ready_mode == 1) & rng[3]);
  end

  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_bit("mtvec init", csr_mtvec_init_o, boot_set);
      // granted requests that have not yet returned keep the stage busy
      if (in_flight > 0) begin
        check_bit("busy with requests in flight", if_busy_o, 1'b1);
      end else if (!instr_req_o) begin
        check_bit("busy while idle", if_busy_o, 1'b0);
      end
      in_flight = in_flight + int'(instr_req_o && instr_gnt_i) - int'(instr_rvalid_i);
      if (instr_new_id_o && instr_valid_id_o) begin
        // this word sat at the FIFO head one cycle ago
        check_addr("pc_if", head_pc, exp_q);
        check_addr("pc_id", pc_id_o, exp_q);
        check_instr("rdata", instr_rdata_id_o, exp_instr(exp_q));
        check_bit("fetch err", instr_fetch_err_o, exp_err(exp_q));
        exp_q = exp_q + 4;
        n_words++;
      end else if (prev_clear && !instr_new_id_o) begin
        check_bit("valid after clear", instr_valid_id_o, 1'b0);
      end
      // words after this point belong to the new stream
      if (pc_set_i) begin
        exp_q = exp_fetch_addr(pc_mux_i, exc_pc_mux_i, irq_vec_i, irq_int_i,
                               branch_target_i) & 32'hFFFF_FFFC;
      end
      prev_clear = instr_valid_clear_i;
      head_pc = pc_if_o;
    end
  end

  task automatic set_pc(input pc_sel_e mux, input exc_pc_sel_e emux, input irq_vec_t vec,
                        input logic intr, input addr_t target);
    @(posedge clk_i);
    pc_set_i <= 1'b1;
    // only a boot entry loads the mtvec reset value
    boot_set <= (mux == PC_BOOT);
    pc_mux_i <= mux;
    exc_pc_mux_i <= emux;
    irq_vec_i <= vec;
    irq_int_i <= intr;
    branch_target_i <= target;
    @(posedge clk_i);
    pc_set_i <= 1'b0;
    boot_set <= 1'b0;
  endtask

  task automatic wait_words(input int n);
    int start;
    int cnt;
    start = n_words;
    cnt = 0;
    while (n_words < start + n) begin
      @(posedge clk_i);
      cnt++;
      if (cnt > 40 * n + 100) begin
        $display("timeout while waiting for %0d instructions", n);
        $display("Regression failed");
        $finish;
      end
    end
  endtask

  task automatic report(input int num, input string name, input int err0);
    $display("test %0d %s done, %0d errors", num, name, errors - err0);
  endtask

  initial begin
    int e0;
    int k;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    req_i <= 1'b1;
    // test 1
    e0 = errors;
    set_pc(PC_BOOT, EXC_PC_EXC, '0, 1'b0, '0);
    wait_words(12);
    report(1, "boot", e0);
    // test 2
    e0 = errors;
    set_pc(PC_JUMP, EXC_PC_EXC, '0, 1'b0, 32'h0000_4204);
    wait_words(3);
    set_pc(PC_ERET, EXC_PC_EXC, '0, 1'b0, '0);
    wait_words(3);
    set_pc(PC_DRET, EXC_PC_EXC, '0, 1'b0, '0);
    wait_words(3);
    for (k = 0; k < 4; k++) begin
      set_pc(PC_EXC, exc_pc_sel_e'(k), 5'd7, 1'b0, '0);
      wait_words(3);
    end
    set_pc(PC_EXC, EXC_PC_IRQ, 5'd0, 1'b0, '0);
    wait_words(2);
    set_pc(PC_EXC, EXC_PC_IRQ, 5'd17, 1'b0, '0);
    wait_words(2);
    set_pc(PC_EXC, EXC_PC_IRQ, 5'd3, 1'b1, '0);
    wait_words(2);
    report(2, "pc sources", e0);
    // test 3
    e0 = errors;
    @(negedge clk_i);
    ready_mode = 1;
    set_pc(PC_JUMP, EXC_PC_EXC, '0, 1'b0, 32'h0000_9000);
    wait_words(200);
    report(3, "back-pressure", e0);
    // test 4, crosses 0x2E00 to 0x2EFF
    e0 = errors;
    set_pc(PC_JUMP, EXC_PC_EXC, '0, 1'b0, 32'h0000_2DF8);
    wait_words(70);
    report(4, "bus errors", e0);
    // test 5
    e0 = errors;
    for (k = 0; k < 8; k++) begin
      @(negedge clk_i);
      ready_mode = 2;
      // short stalls branch with requests in flight, long ones with a full FIFO
      repeat (2 + int'(rng[3:0])) @(negedge clk_i);
      set_pc(PC_JUMP, EXC_PC_EXC, '0, 1'b0, 32'h0000_6000 + {rng[11:4], 2'b00});
      @(negedge clk_i);
      ready_mode = 1;
      wait_words(5);
    end
    report(5, "flush", e0);
    @(negedge clk_i);
    ready_mode = 0;
    repeat (4) @(negedge clk_i);
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_instr_mem.sv */
// instruction memory model for the fetch testbench
// data is the inverse of the word address, bits 11:8 equal to E give a bus error
// grant after 0 to 3 cycles, responses in order 1 to 4 cycles after the grant
`timescale 1ns/1ns
`default_nettype none

module tb_instr_mem import if_pkg::*; #(
  parameter logic [31:0] Seed = 32'h3893b28f
) (
  input  wire         clk_i,
  input  wire         rst_ni,
  input  wire         req_i,
  input  addr_t       addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output instr_t      rdata_o,
  output logic        err_o
);

  logic [31:0] rng_q;
  int          wait_cnt;
  int          cycle;
  int          last_due;
  int          due;
  addr_t       pend_addr[$];
  int          pend_due[$];

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rng_q    <= Seed;
      wait_cnt <= 0;
      cycle    <= 0;
      last_due <= 0;
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
      pend_addr.delete();
      pend_due.delete();
    end else begin
      cycle <= cycle + 1;
      rng_q <= xorshift32(rng_q);
      // response side, one word per cycle in grant order
      rvalid_o <= 1'b0;
      if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
        rvalid_o <= 1'b1;
        rdata_o  <= ~{pend_addr[0][31:2], 2'b00};
        err_o    <= (pend_addr[0][11:8] == 4'hE);
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      // accepted request
      if (req_i && gnt_o) begin
        due = cycle + 1 + int'(rng_q[1:0]);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due <= due;
        pend_addr.push_back(addr_i);
        pend_due.push_back(due);
        wait_cnt <= int'(rng_q[5:4]);
        gnt_o    <= (rng_q[5:4] == 2'd0);
      end else if (req_i && wait_cnt > 0) begin
        // counting down the grant delay
        wait_cnt <= wait_cnt - 1;
        gnt_o    <= (wait_cnt == 1);
      end else begin
        gnt_o <= (wait_cnt == 0);
      end
    end
  end

endmodule

`default_nettype wire
